/* Makefile */
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= tb_scpad_backend
FLIST ?= scpad_backend_top.f
BUILD ?= obj_dir
LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), pass if the log holds the pass line"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* hdl/burst_sequencer.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module burst_sequencer import scpad_pkg::*; (
    input  logic                      bshif,
    input  logic                      arst_n,
    input  logic                      start,
    input  xfer_t                     xfer,
    input  logic                      advance,
    output logic [4:0]                row_idx,
    output logic [2:0]                beat_idx,
    output logic [`SCPAD_DRAM_AW-1:0] dram_addr,
    output logic [3:0]                mask,
    output logic                      last_beat,
    output logic                      last_row
);
    localparam int AW = `SCPAD_DRAM_AW;

    logic [4:0]  row_q;
    logic [2:0]  beat_q;
    logic [10:0] row_off;
    logic        ended_q;

    assign row_idx   = row_q;
    assign beat_idx  = beat_q;
    assign last_beat = (beat_q == xfer.num_cols[4:2]);
    assign last_row  = (row_q == xfer.num_rows);

    // rows are packed back to back in DRAM with no padding
    assign row_off   = 11'(row_q) * (11'(xfer.num_cols) + 11'd1);
    assign dram_addr = xfer.dram_addr + AW'(row_off) + AW'({beat_q, 2'b00});

    // only the tail beat of a row is trimmed to the real column count
    assign mask = last_beat ? (4'hf >> (2'd3 - xfer.num_cols[1:0])) : 4'hf;

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            row_q   <= '0;
            beat_q  <= '0;
            ended_q <= 1'b0;
        end else if (start) begin
            row_q   <= '0;
            beat_q  <= '0;
            ended_q <= 1'b0;
        end else if (advance) begin
            if (last_beat) begin
                beat_q <= '0;
                row_q  <= row_q + 5'd1;
                if (last_row) ended_q <= 1'b1;   // tile fully walked
            end else begin
                beat_q <= beat_q + 3'd1;
            end
        end
    end

    // the owning engine must stop stepping once the tile is finished
    a_no_advance_past_end: assert property (
        @(posedge bshif) disable iff (!arst_n) ended_q |-> !advance
    );

endmodule

/* hdl/load_engine.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module load_engine import scpad_pkg::*; (
    input  logic                     bshif,
    input  logic                     arst_n,
    input  logic                     start,
    input  xfer_t                    xfer,
    output logic                     busy,
    output logic                     done,
    output logic                     dram_valid,
    output dram_req_t                dram_req,
    input  logic                     dram_gnt,
    input  logic                     res_valid,
    input  logic [7:0]               res_id,
    input  logic [`SCPAD_BEAT_W-1:0] res_rdata,
    output logic                     sram_valid,
    output sram_req_t                sram_req,
    input  logic                     sram_gnt
);
    typedef enum logic [1:0] {IDLE, ISSUE, COLLECT} state_t;

    state_t                   state_q;
    xfer_t                    cfg_q;
    logic [4:0]               cur_row_q;
    logic [3:0]               arrived_q;
    logic                     final_q;
    logic [`SCPAD_ROW_W-1:0]  row_buf;
    logic                     accept;
    logic [3:0]               nbeats;
    logic [4:0]               seq_row;
    logic [2:0]               seq_beat;
    logic [`SCPAD_DRAM_AW-1:0] seq_addr;
    logic [3:0]               seq_mask;
    logic                     seq_last_beat;
    logic                     seq_last_row;

    assign accept = start && (state_q == IDLE);
    assign busy   = (state_q != IDLE);
    assign nbeats = {1'b0, cfg_q.num_cols[4:2]} + 4'd1;

    burst_sequencer i_seq (
        .bshif     (bshif),
        .arst_n    (arst_n),
        .start     (accept),
        .xfer      (cfg_q),
        .advance   (dram_gnt),
        .row_idx   (seq_row),
        .beat_idx  (seq_beat),
        .dram_addr (seq_addr),
        .mask      (seq_mask),
        .last_beat (seq_last_beat),
        .last_row  (seq_last_row)
    );

    always_comb begin
        dram_valid     = (state_q == ISSUE);
        dram_req.write = 1'b0;
        dram_req.id    = {seq_row, seq_beat};
        dram_req.addr  = seq_addr;
        dram_req.mask  = seq_mask;
        dram_req.wdata = '0;
    end

    // the row goes out once every beat of it has come back
    always_comb begin
        sram_valid     = (state_q == COLLECT) && (arrived_q == nbeats);
        sram_req.write = 1'b1;
        sram_req.addr  = cfg_q.spad_row + `SCPAD_ROW_AW'(cur_row_q);
        sram_req.wdata = row_buf;
        sram_req.bmask = 32'hffff_ffff >> (5'd31 - cfg_q.num_cols);
    end

    always_ff @(posedge bshif) begin
        if (accept) cfg_q <= xfer;
        if (res_valid) row_buf[{res_id[2:0], 5'd0} +: `SCPAD_BEAT_W] <= res_rdata;  // beat slot
    end

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            done      <= 1'b0;
            cur_row_q <= '0;
            arrived_q <= '0;
            final_q   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (res_valid) arrived_q <= arrived_q + 4'd1;
            case (state_q)
                IDLE: if (accept) begin
                    state_q   <= ISSUE;
                    cur_row_q <= '0;
                    arrived_q <= '0;
                end
                ISSUE: if (dram_gnt && seq_last_beat) begin
                    state_q <= COLLECT;
                    final_q <= seq_last_row;   // remember whether this row ends the tile
                end
                COLLECT: if (sram_gnt) begin
                    arrived_q <= '0;
                    cur_row_q <= cur_row_q + 5'd1;
                    if (final_q) begin
                        state_q <= IDLE;
                        done    <= 1'b1;
                    end else begin
                        state_q <= ISSUE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_no_start_busy: assert property (@(posedge bshif) disable iff (!arst_n) busy |-> !start);

    // reads of the next row only go out after this row is written
    a_res_cur_row: assert property (
        @(posedge bshif) disable iff (!arst_n)
        res_valid |-> (state_q != IDLE) && (res_id[7:3] == cur_row_q)
    );

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
    parameter type payload_t = logic
) (
    input  logic       bshif,
    input  logic       arst_n,
    input  logic [1:0] valid,
    input  payload_t   payload [2],
    input  logic       ready,
    output logic [1:0] gnt,
    output logic       out_valid,
    output payload_t   out_payload
);
    logic prio_q;       // client that wins a tie
    logic hold_q;       // the last offered request was not taken
    logic hold_sel_q;   // client whose request is still waiting
    logic sel;

    // fall back to the other client when the favoured one is idle
    always_comb begin
        sel = prio_q;
        if (!valid[prio_q]) sel = ~prio_q;
        if (hold_q) sel = hold_sel_q;   // a waiting request keeps the output until taken
    end

    assign out_valid   = |valid;
    assign out_payload = payload[sel];

    always_comb begin
        gnt = '0;
        if (ready && valid[sel]) gnt[sel] = 1'b1;
    end

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            prio_q     <= 1'b0;
            hold_q     <= 1'b0;
            hold_sel_q <= 1'b0;
        end else begin
            if (|gnt) prio_q <= ~sel;   // the loser goes first next time
            hold_q     <= out_valid && !ready;
            hold_sel_q <= sel;
        end
    end

    // a client that was refused keeps offering the same request
    a_hold_stable: assert property (
        @(posedge bshif) disable iff (!arst_n)
        out_valid && !ready |=> out_valid && $stable(out_payload)
    );

endmodule

/* hdl/scpad_backend_top.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module scpad_backend_top import scpad_pkg::*; (
    input  logic                      bshif,
    input  logic                      arst_n,
    input  logic                      ld_start,
    input  logic [`SCPAD_ROW_AW-1:0]  ld_spad_row,
    input  logic [`SCPAD_DRAM_AW-1:0] ld_dram_addr,
    input  logic [4:0]                ld_num_rows,
    input  logic [4:0]                ld_num_cols,
    output logic                      ld_busy,
    output logic                      ld_done,
    input  logic                      st_start,
    input  logic [`SCPAD_ROW_AW-1:0]  st_spad_row,
    input  logic [`SCPAD_DRAM_AW-1:0] st_dram_addr,
    input  logic [4:0]                st_num_rows,
    input  logic [4:0]                st_num_cols,
    output logic                      st_busy,
    output logic                      st_done,
    output logic                      dram_req_valid,
    output logic                      dram_req_write,
    output logic [7:0]                dram_req_id,
    output logic [`SCPAD_DRAM_AW-1:0] dram_req_addr,
    output logic [3:0]                dram_req_mask,
    output logic [`SCPAD_BEAT_W-1:0]  dram_req_wdata,
    input  logic                      dram_stall,
    input  logic                      dram_res_valid,
    input  logic [7:0]                dram_res_id,
    input  logic [`SCPAD_BEAT_W-1:0]  dram_res_rdata
);
    xfer_t                   ld_xfer, st_xfer;
    logic [1:0]              dram_valid, dram_gnt, sram_valid, sram_gnt;
    dram_req_t               dram_reqs [2];
    sram_req_t               sram_reqs [2];
    dram_req_t               dram_out;
    sram_req_t               sram_out;
    logic                    sram_out_valid;
    logic [`SCPAD_ROW_W-1:0] sram_rdata;

    assign ld_xfer = '{spad_row: ld_spad_row, dram_addr: ld_dram_addr,
                       num_rows: ld_num_rows, num_cols: ld_num_cols};
    assign st_xfer = '{spad_row: st_spad_row, dram_addr: st_dram_addr,
                       num_rows: st_num_rows, num_cols: st_num_cols};

    // client 0 is the load engine on both arbiters
    load_engine i_load (
        .bshif(bshif), .arst_n(arst_n), .start(ld_start), .xfer(ld_xfer),
        .busy(ld_busy), .done(ld_done),
        .dram_valid(dram_valid[0]), .dram_req(dram_reqs[0]), .dram_gnt(dram_gnt[0]),
        .res_valid(dram_res_valid), .res_id(dram_res_id), .res_rdata(dram_res_rdata),
        .sram_valid(sram_valid[0]), .sram_req(sram_reqs[0]), .sram_gnt(sram_gnt[0])
    );

    store_engine i_store (
        .bshif(bshif), .arst_n(arst_n), .start(st_start), .xfer(st_xfer),
        .busy(st_busy), .done(st_done),
        .sram_valid(sram_valid[1]), .sram_req(sram_reqs[1]), .sram_gnt(sram_gnt[1]),
        .sram_rdata(sram_rdata),
        .dram_valid(dram_valid[1]), .dram_req(dram_reqs[1]), .dram_gnt(dram_gnt[1])
    );

    rr_arbiter #(.payload_t(dram_req_t)) i_dram_arb (
        .bshif(bshif), .arst_n(arst_n), .valid(dram_valid), .payload(dram_reqs),
        .ready(!dram_stall), .gnt(dram_gnt),
        .out_valid(dram_req_valid), .out_payload(dram_out)
    );

    rr_arbiter #(.payload_t(sram_req_t)) i_sram_arb (
        .bshif(bshif), .arst_n(arst_n), .valid(sram_valid), .payload(sram_reqs),
        .ready(1'b1), .gnt(sram_gnt),
        .out_valid(sram_out_valid), .out_payload(sram_out)
    );

    scpad_sram i_sram (
        .bshif(bshif), .arst_n(arst_n), .valid(sram_out_valid), .req(sram_out),
        .rvalid(), .rdata(sram_rdata)
    );

    assign dram_req_write = dram_out.write;
    assign dram_req_id    = dram_out.id;
    assign dram_req_addr  = dram_out.addr;
    assign dram_req_mask  = dram_out.mask;
    assign dram_req_wdata = dram_out.wdata;

endmodule

/* hdl/scpad_pkg.sv */
`include "scpad_defs.svh"

package scpad_pkg;

    // one tile transfer as issued by the scheduler
    typedef struct packed {
        logic [`SCPAD_ROW_AW-1:0]  spad_row;
        logic [`SCPAD_DRAM_AW-1:0] dram_addr;
        logic [4:0]                num_rows;   // row count minus one
        logic [4:0]                num_cols;   // column count minus one
    } xfer_t;

    // one DRAM beat, id carries row in [7:3] and beat in [2:0]
    typedef struct packed {
        logic                      write;
        logic [7:0]                id;
        logic [`SCPAD_DRAM_AW-1:0] addr;
        logic [`SCPAD_BEAT_ELEMS-1:0] mask;
        logic [`SCPAD_BEAT_W-1:0]  wdata;
    } dram_req_t;

    // one whole scratchpad row access
    typedef struct packed {
        logic                        write;
        logic [`SCPAD_ROW_AW-1:0]    addr;
        logic [`SCPAD_ROW_W-1:0]     wdata;
        logic [`SCPAD_ROW_ELEMS-1:0] bmask;
    } sram_req_t;

endpackage

/* hdl/scpad_sram.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module scpad_sram import scpad_pkg::*; (
    input  logic                    bshif,
    input  logic                    arst_n,
    input  logic                    valid,
    input  sram_req_t               req,
    output logic                    rvalid,
    output logic [`SCPAD_ROW_W-1:0] rdata
);
    logic [`SCPAD_ROW_W-1:0] mem [`SCPAD_DEPTH];

    always_ff @(posedge bshif) begin
        if (valid && req.write) begin
            for (int i = 0; i < `SCPAD_ROW_ELEMS; i++) begin
                if (req.bmask[i]) begin
                    mem[req.addr][i*`SCPAD_ELEM_W +: `SCPAD_ELEM_W] <=
                        req.wdata[i*`SCPAD_ELEM_W +: `SCPAD_ELEM_W];
                end
            end
        end
        if (valid && !req.write) rdata <= mem[req.addr];   // registered read port
    end

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= valid && !req.write;
        end
    end

    // a row write always carries at least one element
    a_write_mask: assert property (
        @(posedge bshif) disable iff (!arst_n) valid && req.write |-> (req.bmask != '0)
    );

endmodule

/* hdl/store_engine.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module store_engine import scpad_pkg::*; (
    input  logic                    bshif,
    input  logic                    arst_n,
    input  logic                    start,
    input  xfer_t                   xfer,
    output logic                    busy,
    output logic                    done,
    output logic                    sram_valid,
    output sram_req_t               sram_req,
    input  logic                    sram_gnt,
    input  logic [`SCPAD_ROW_W-1:0] sram_rdata,
    output logic                    dram_valid,
    output dram_req_t               dram_req,
    input  logic                    dram_gnt
);
    typedef enum logic [1:0] {IDLE, READ, WAIT, SEND} state_t;

    state_t                    state_q;
    xfer_t                     cfg_q;
    logic [`SCPAD_ROW_W-1:0]   row_q;
    logic                      accept;
    logic [4:0]                seq_row;
    logic [2:0]                seq_beat;
    logic [`SCPAD_DRAM_AW-1:0] seq_addr;
    logic [3:0]                seq_mask;
    logic                      seq_last_beat;
    logic                      seq_last_row;

    assign accept = start && (state_q == IDLE);
    assign busy   = (state_q != IDLE);

    burst_sequencer i_seq (
        .bshif     (bshif),
        .arst_n    (arst_n),
        .start     (accept),
        .xfer      (cfg_q),
        .advance   (dram_gnt),
        .row_idx   (seq_row),
        .beat_idx  (seq_beat),
        .dram_addr (seq_addr),
        .mask      (seq_mask),
        .last_beat (seq_last_beat),
        .last_row  (seq_last_row)
    );

    // the sequencer sits on beat zero of the row to fetch while reading
    always_comb begin
        sram_valid     = (state_q == READ);
        sram_req.write = 1'b0;
        sram_req.addr  = cfg_q.spad_row + `SCPAD_ROW_AW'(seq_row);
        sram_req.wdata = '0;
        sram_req.bmask = '0;
    end

    always_comb begin
        dram_valid     = (state_q == SEND);
        dram_req.write = 1'b1;
        dram_req.id    = '0;   // writes get no response
        dram_req.addr  = seq_addr;
        dram_req.mask  = seq_mask;
        dram_req.wdata = row_q[{seq_beat, 5'd0} +: `SCPAD_BEAT_W];
    end

    always_ff @(posedge bshif) begin
        if (accept) cfg_q <= xfer;
        if (state_q == WAIT) row_q <= sram_rdata;   // read data lands one cycle after grant
    end

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                IDLE:    if (accept) state_q <= READ;
                READ:    if (sram_gnt) state_q <= WAIT;
                WAIT:    state_q <= SEND;
                SEND: if (dram_gnt && seq_last_beat) begin
                    if (seq_last_row) begin
                        state_q <= IDLE;
                        done    <= 1'b1;
                    end else begin
                        state_q <= READ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_no_start_busy: assert property (@(posedge bshif) disable iff (!arst_n) busy |-> !start);

endmodule

/* include/scpad_defs.svh */
`ifndef SCPAD_DEFS_SVH
`define SCPAD_DEFS_SVH

// element and beat geometry
`define SCPAD_ELEM_W      8
`define SCPAD_BEAT_ELEMS  4
`define SCPAD_BEAT_W      (`SCPAD_ELEM_W * `SCPAD_BEAT_ELEMS)

// one scratchpad row is 32 byte-wide elements
`define SCPAD_ROW_ELEMS   32
`define SCPAD_ROW_W       (`SCPAD_ELEM_W * `SCPAD_ROW_ELEMS)

`define SCPAD_DEPTH       64
`define SCPAD_ROW_AW      6
`define SCPAD_DRAM_AW     20

`endif

/* scpad_backend_top.f */
+incdir+include
hdl/scpad_pkg.sv
hdl/burst_sequencer.sv
hdl/load_engine.sv
hdl/store_engine.sv
hdl/rr_arbiter.sv
hdl/scpad_sram.sv
hdl/scpad_backend_top.sv
test/tb_dram_model.sv
test/tb_scpad_backend.sv

/* test/tb_dram_model.sv */
`timescale 1ns/1ps

module tb_dram_model (
    input  logic        bshif,
    input  logic        arst_n,
    input  int          stall_pct,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [7:0]  req_id,
    input  logic [19:0] req_addr,
    input  logic [3:0]  req_mask,
    input  logic [31:0] req_wdata,
    output logic        stall,
    output logic        res_valid,
    output logic [7:0]  res_id,
    output logic [31:0] res_rdata
);
    localparam int MEM_BYTES = 16384;

    logic [7:0] mem [MEM_BYTES];
    logic [7:0] pend_id [$];
    int         pend_addr [$];
    int         pend_wait [$];   // cycles left before a read may answer
    int         writes_taken = 0;

    task automatic fill_image();
        for (int i = 0; i < MEM_BYTES; i++) mem[i] = 8'($urandom);
    endtask

    initial begin
        stall     = 1'b0;
        res_valid = 1'b0;
        res_id    = '0;
        res_rdata = '0;
    end

    // a request is taken when it is valid and not stalled
    always @(negedge bshif) begin
        if (arst_n && req_valid && !stall) begin
            if (req_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_mask[b]) mem[(int'(req_addr) + b) % MEM_BYTES] = req_wdata[b*8 +: 8];
                end
                writes_taken++;
            end else begin
                pend_id.push_back(req_id);
                pend_addr.push_back(int'(req_addr));
                pend_wait.push_back(int'($urandom_range(6, 0)));
            end
        end
    end

    always @(posedge bshif) begin : respond
        int ready_idx [$];
        int pick;
        int a;
        #1;
        stall     = arst_n && (int'($urandom_range(99, 0)) < stall_pct);
        res_valid = 1'b0;
        ready_idx = {};
        for (int k = 0; k < pend_wait.size(); k++) begin
            if (pend_wait[k] > 0) pend_wait[k]--;
            else ready_idx.push_back(k);
        end
        if (ready_idx.size() > 0) begin
            // any ready read may answer first, which reorders responses
            pick      = ready_idx[$urandom_range(ready_idx.size() - 1, 0)];
            a         = pend_addr[pick];
            res_valid = 1'b1;
            res_id    = pend_id[pick];
            res_rdata = {mem[(a+3) % MEM_BYTES], mem[(a+2) % MEM_BYTES],
                         mem[(a+1) % MEM_BYTES], mem[a % MEM_BYTES]};
            pend_id.delete(pick);
            pend_addr.delete(pick);
            pend_wait.delete(pick);
        end
    end

endmodule

/* test/tb_scpad_backend.sv */
`timescale 1ns/1ps
`include "scpad_defs.svh"

module tb_scpad_backend import scpad_pkg::*; ();
    localparam int MEM_BYTES = 16384;
    localparam int LIMIT     = 20000;

    typedef struct {
        string name;
        int    src;
        int    spad;
        int    dst;
        int    rows;      // count minus one
        int    cols;      // count minus one
        int    stall;     // percent of stalled cycles
        bit    overlap;   // next load starts with this store
    } entry_t;

    logic        bshif, arst_n, ld_start, st_start, ld_busy, ld_done, st_busy, st_done;
    logic [5:0]  ld_spad_row, st_spad_row;
    logic [19:0] ld_dram_addr, st_dram_addr, dram_req_addr;
    logic [4:0]  ld_num_rows, ld_num_cols, st_num_rows, st_num_cols;
    logic        dram_req_valid, dram_req_write, dram_stall, dram_res_valid;
    logic [7:0]  dram_req_id, dram_res_id;
    logic [3:0]  dram_req_mask;
    logic [31:0] dram_req_wdata, dram_res_rdata;
    int          stall_pct;

    entry_t      table_q [$];
    dram_req_t   exp_beats [$];
    dram_req_t   held_req;
    logic        held_valid = 1'b0;
    logic [7:0]  ref_mem [MEM_BYTES];
    logic [7:0]  ref_spad [64][32];
    int          ld_done_cnt = 0, st_done_cnt = 0;
    int          err_value = 0, err_other = 0;
    bit          timed_out = 0;
    string       cur_name = "reset";

    initial bshif = 1'b0;
    always #5 bshif = ~bshif;

    scpad_backend_top i_dut (.*);

    tb_dram_model i_mem (
        .bshif(bshif), .arst_n(arst_n), .stall_pct(stall_pct),
        .req_valid(dram_req_valid), .req_write(dram_req_write), .req_id(dram_req_id),
        .req_addr(dram_req_addr), .req_mask(dram_req_mask), .req_wdata(dram_req_wdata),
        .stall(dram_stall), .res_valid(dram_res_valid), .res_id(dram_res_id),
        .res_rdata(dram_res_rdata)
    );

    task automatic check_beat(input string name, input dram_req_t exp, input dram_req_t act);
        logic [31:0] keep;
        for (int i = 0; i < 4; i++) keep[i*8 +: 8] = {8{exp.mask[i]}};
        if (exp.write !== act.write || exp.id !== act.id || exp.addr !== act.addr ||
            exp.mask !== act.mask || (exp.wdata & keep) !== (act.wdata & keep)) begin
            $display(
                "[FAIL] %s exp id=%h addr=%h mask=%b data=%h act id=%h addr=%h mask=%b data=%h",
                name, exp.id, exp.addr, exp.mask, exp.wdata & keep,
                act.id, act.addr, act.mask, act.wdata & keep);
            err_value++;
        end
    endtask

    task automatic check_done(input string name, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
            err_value++;
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %b actual %b", name, what, exp, act);
            err_value++;
        end
    endtask

    task automatic check_byte(input string name, input int addr, input logic [7:0] exp,
                              input logic [7:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s dram[%h] expected %h actual %h", name, addr, exp, act);
            err_value++;
        end
    endtask

    task automatic add_entry(input string name, input int src, input int spad, input int dst,
                             input int rows, input int cols, input int stall, input bit overlap);
        entry_t e;
        e = '{name, src, spad, dst, rows, cols, stall, overlap};
        table_q.push_back(e);
    endtask

    // row r of the tile starts (cols + 1) bytes after row r - 1
    task automatic load_reference(input entry_t e);
        for (int r = 0; r <= e.rows; r++) begin
            for (int c = 0; c <= e.cols; c++) begin
                ref_spad[(e.spad + r) % 64][c] = ref_mem[e.src + r * (e.cols + 1) + c];
            end
        end
    endtask

    task automatic store_reference(input entry_t e);
        dram_req_t beat;
        int        n;
        for (int r = 0; r <= e.rows; r++) begin
            for (int b = 0; b <= e.cols / 4; b++) begin
                n          = (b == e.cols / 4) ? (e.cols % 4) + 1 : 4;   // tail beat is trimmed
                beat       = '0;
                beat.write = 1'b1;
                beat.addr  = 20'(e.dst + r * (e.cols + 1) + 4 * b);
                for (int i = 0; i < n; i++) begin
                    beat.mask[i]        = 1'b1;
                    beat.wdata[i*8 +: 8] = ref_spad[(e.spad + r) % 64][4*b + i];
                    ref_mem[e.dst + r * (e.cols + 1) + 4*b + i] =
                        ref_spad[(e.spad + r) % 64][4*b + i];
                end
                exp_beats.push_back(beat);
            end
        end
    endtask

    task automatic launch(input bit do_ld, input int li, input bit do_st, input int si);
        @(posedge bshif);
        #1;
        if (do_ld) begin
            ld_start     = 1'b1;
            ld_spad_row  = 6'(table_q[li].spad);
            ld_dram_addr = 20'(table_q[li].src);
            ld_num_rows  = 5'(table_q[li].rows);
            ld_num_cols  = 5'(table_q[li].cols);
            load_reference(table_q[li]);
        end
        if (do_st) begin
            st_start     = 1'b1;
            st_spad_row  = 6'(table_q[si].spad);
            st_dram_addr = 20'(table_q[si].dst);
            st_num_rows  = 5'(table_q[si].rows);
            st_num_cols  = 5'(table_q[si].cols);
            store_reference(table_q[si]);
        end
        @(posedge bshif);
        #1;
        ld_start = 1'b0;
        st_start = 1'b0;
        if (do_ld) check_flag(cur_name, "ld_busy after start", 1'b1, ld_busy);
        if (do_st) check_flag(cur_name, "st_busy after start", 1'b1, st_busy);
    endtask

    task automatic wait_done(input int ld_target, input int st_target);
        int cycles;
        cycles = 0;
        while ((ld_done_cnt < ld_target || st_done_cnt < st_target) && cycles < LIMIT) begin
            @(posedge bshif);
            cycles++;
        end
        if (ld_done_cnt < ld_target || st_done_cnt < st_target) begin
            $display("timeout in %s: the transfer never signalled done", cur_name);
            err_other++;
            timed_out = 1'b1;
        end
    endtask

    task automatic compare_dram(input string name);
        int bad;
        bad = 0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            if (ref_mem[a] !== i_mem.mem[a]) begin
                if (bad < 8) check_byte(name, a, ref_mem[a], i_mem.mem[a]);
                else err_value++;
                bad++;
            end
        end
        if (bad > 8) $display("%0d more DRAM bytes differ in %s", bad - 8, name);
    endtask

    // done pulses, write beats and stall holding are watched mid-cycle
    always @(negedge bshif) begin : monitor
        dram_req_t cur;
        cur = '{write: dram_req_write, id: dram_req_id, addr: dram_req_addr,
                mask: dram_req_mask, wdata: dram_req_wdata};
        if (arst_n) begin
            if (ld_done) ld_done_cnt++;
            if (st_done) st_done_cnt++;
            if (held_valid) begin
                if (!dram_req_valid) begin
                    $display("a stalled DRAM request was dropped in %s", cur_name);
                    err_other++;
                end else if (cur !== held_req) begin
                    $display("a stalled DRAM request changed before it was taken in %s", cur_name);
                    err_other++;
                end
            end
            held_valid = dram_req_valid && dram_stall;
            held_req   = cur;
            if (dram_req_valid && !dram_stall && dram_req_write) begin
                if (exp_beats.size() == 0) begin
                    $display("unexpected DRAM write beat at %h in %s", dram_req_addr, cur_name);
                    err_other++;
                end else begin
                    check_beat(cur_name, exp_beats.pop_front(), cur);
                end
            end
        end
    end

    initial begin : main
        int ld_exp, st_exp, beats_before, beats_exp;
        bit ld_running, ov;
        void'($urandom(32'h3b0d_f1fd));
        {arst_n, ld_start, st_start} = '0;
        {ld_spad_row, ld_dram_addr, ld_num_rows, ld_num_cols} = '0;
        {st_spad_row, st_dram_addr, st_num_rows, st_num_cols} = '0;
        stall_pct = 0;
        i_mem.fill_image();
        for (int a = 0; a < MEM_BYTES; a++) ref_mem[a] = i_mem.mem[a];

        add_entry("full_32x32",  'h0000,  0, 'h1000, 31, 31, 25, 1'b0);
        add_entry("narrow_7x13", 'h0400, 32, 'h1400,  6, 12, 25, 1'b1);
        add_entry("overlap_6col",'h0800, 40, 'h1800,  9,  5, 25, 1'b0);
        add_entry("heavy_stall", 'h0c00,  0, 'h2000,  3, 30, 75, 1'b0);
        add_entry("single_byte", 'h0a13, 63, 'h2801,  0,  0, 25, 1'b0);

        repeat (3) @(posedge bshif);
        #1 arst_n = 1'b1;
        check_flag("reset", "ld_busy", 1'b0, ld_busy);
        check_flag("reset", "st_busy", 1'b0, st_busy);

        ld_exp     = 0;
        st_exp     = 0;
        ld_running = 1'b0;
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            cur_name     = table_q[i].name;
            stall_pct    = table_q[i].stall;
            beats_before = i_mem.writes_taken;
            beats_exp    = (table_q[i].rows + 1) * (table_q[i].cols / 4 + 1);
            if (!ld_running) begin
                launch(1'b1, i, 1'b0, i);
                ld_exp++;
                wait_done(ld_exp, st_exp);
            end
            if (timed_out) break;
            ov = table_q[i].overlap && (i + 1 < table_q.size());
            launch(ov, i + 1, 1'b1, i);
            if (ov) ld_exp++;
            st_exp++;
            wait_done(ld_exp, st_exp);
            ld_running = ov;
            repeat (3) @(posedge bshif);
            check_done(cur_name, "ld_done count", ld_exp, ld_done_cnt);
            check_done(cur_name, "st_done count", st_exp, st_done_cnt);
            check_done(cur_name, "write beats", beats_exp, i_mem.writes_taken - beats_before);
            check_done(cur_name, "missing write beats", 0, exp_beats.size());
            compare_dram(cur_name);
        end

        $display("errors: value %0d other %0d", err_value, err_other);
        if (err_value == 0 && err_other == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
